// File: bus_ram.sv
`timescale 1ns/1ns

module bus_ram (
	input logic i_clock,
	input logic i_rst,
	mem_bus_if.slave bus
);
	import wb_pkg::*;

	logic [DATA_W-1:0] mem [RAM_WORDS];
	logic [RAM_IDX_W-1:0] word_idx;
	logic [2:0] lfsr;
	logic [1:0] wait_cnt;
	logic busy;

	// Power-up contents, reset leaves them alone
	initial begin
		for (int i = 0; i < RAM_WORDS; i++)
			mem[i] = '0;
	end

	// Word addressed, byte offset ignored
	assign word_idx = bus.address[RAM_IDX_W+1:2];

	assign bus.ready = busy && (wait_cnt == 2'd0);
	assign bus.rdata = (bus.ready && !bus.rw) ? mem[word_idx] : '0;

	// Wait-state generator
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			lfsr <= 3'b101;
			busy <= 1'b0;
			wait_cnt <= 2'd0;
		end else begin
			// x^3 + x^2 + 1, never reaches zero
			lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};

			if (!busy) begin
				// New request, ready after 1 to 4 cycles
				if (bus.request) begin
					busy <= 1'b1;
					wait_cnt <= lfsr[1:0];
				end
			end else if (wait_cnt == 2'd0) begin
				busy <= 1'b0;
			end else begin
				wait_cnt <= wait_cnt - 1'b1;
			end
		end
	end

	// Write lands on the ready edge
	always_ff @(posedge i_clock) begin
		if (bus.ready && bus.rw)
			mem[word_idx] <= bus.wdata;
	end

endmodule

// File: fifo_if.sv
`timescale 1ns/1ns

interface fifo_if;
	import wb_pkg::*;

	// Push side
	logic write;
	write_entry_t wdata;

	// Pop side, rdata shows the oldest entry
	logic read;
	write_entry_t rdata;

	// Occupancy flags
	logic empty;
	logic full;

	modport ctrl (
		output write,
		output wdata,
		output read,
		input rdata,
		input empty,
		input full
	);

	modport queue (
		input write,
		input wdata,
		input read,
		output rdata,
		output empty,
		output full
	);

endinterface

// File: flist.f
wb_pkg.sv
fifo_if.sv
mem_bus_if.sv
wb_fifo.sv
write_buffer.sv
bus_ram.sv
wb_subsystem.sv
wb_subsystem_assert.sv
tb_wb_subsystem.sv

// File: mem_bus_if.sv
`timescale 1ns/1ns

interface mem_bus_if;
	import wb_pkg::*;

	// Held by the master until ready
	logic request;
	logic rw;
	logic [ADDR_W-1:0] address;
	logic [DATA_W-1:0] wdata;

	// One-cycle completion pulse and read word
	logic ready;
	logic [DATA_W-1:0] rdata;

	modport master (
		output request,
		output rw,
		output address,
		output wdata,
		input ready,
		input rdata
	);

	modport slave (
		input request,
		input rw,
		input address,
		input wdata,
		output ready,
		output rdata
	);

endinterface

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run the testbench and judge the run from its log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_wb_subsystem -f flist.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| echo "Build or simulation returned an error"

cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

// File: tb_wb_subsystem.sv
`timescale 1ns/1ns

module tb_wb_subsystem;
	import wb_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 8;
	localparam int N_TRANSFERS = 2000;
	localparam int N_UNTOUCHED = 16;
	localparam int HOT_WORDS = 64;
	localparam int CYCLES_PER_TRANSFER = 20;
	localparam int DRAIN_BOUND = WQ_DEPTH * 5 + 2;
	localparam int WATCHDOG_NS = (N_TRANSFERS + N_UNTOUCHED) * CYCLES_PER_TRANSFER * CLK_PERIOD;
	localparam logic [31:0] SEED = 32'hd90d_7284;

	logic i_clock;
	logic i_rst;
	logic i_request;
	logic i_rw;
	logic [ADDR_W-1:0] i_address;
	logic [DATA_W-1:0] i_wdata;
	logic o_ready;
	logic [DATA_W-1:0] o_rdata;
	logic o_empty;

	// Reference memory, words never written read as zero
	logic [DATA_W-1:0] model [int];

	int mismatch_errors = 0;
	int other_errors = 0;
	int reads_checked = 0;
	int writes_done = 0;

	wb_subsystem #(
		.P_STALL_READ(1'b1)
	) wb_subsystem_i (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_empty(o_empty)
	);

	initial begin
		i_clock = 1'b0;
		forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
	end

	// Worst case budget per transfer, covers stalls behind a full queue
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: run still busy after %0d ns", WATCHDOG_NS);
		$display("Test FAILED");
		$finish;
	end

	// Random upper bits and byte offset, the RAM only decodes bits 9:2
	function automatic logic [ADDR_W-1:0] build_address(input int unsigned word);
		logic [ADDR_W-1:0] addr;
		addr = $urandom;
		addr[RAM_IDX_W+1:2] = RAM_IDX_W'(word);
		return addr;
	endfunction

	task automatic check_idle_outputs();
		if (o_ready !== 1'b0) begin
			mismatch_errors++;
			$display("mismatch at %0t: o_ready expected 0, actual %b", $time, o_ready);
		end
		if (o_empty !== 1'b1) begin
			mismatch_errors++;
			$display("mismatch at %0t: o_empty expected 1, actual %b", $time, o_empty);
		end
	endtask

	// Called on a falling edge, returns on the falling edge after completion
	task automatic run_transfer(input logic rw, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] data);
		logic [RAM_IDX_W-1:0] idx;
		logic [DATA_W-1:0] expected;
		idx = addr[RAM_IDX_W+1:2];
		i_request = 1'b1;
		i_rw = rw;
		i_address = addr;
		i_wdata = data;
		#1;
		while (o_ready !== 1'b1) begin
			@(negedge i_clock);
			#1;
		end
		if (rw) begin
			model[int'(idx)] = data;
			writes_done++;
		end else begin
			expected = model.exists(int'(idx)) ? model[int'(idx)] : '0;
			if (o_rdata !== expected) begin
				mismatch_errors++;
				$display("mismatch at %0t: o_rdata expected %h, actual %h (word %0d)",
					$time, expected, o_rdata, idx);
			end
			// A stalled read only completes once every write has drained
			if (o_empty !== 1'b1) begin
				mismatch_errors++;
				$display("mismatch at %0t: o_empty expected 1, actual %b", $time, o_empty);
			end
			reads_checked++;
		end
		@(negedge i_clock);
	endtask

	task automatic idle_cycles(input int n);
		i_request = 1'b0;
		repeat (n) @(negedge i_clock);
	endtask

	task automatic check_drain();
		int cycles;
		cycles = 0;
		i_request = 1'b0;
		#1;
		while (o_empty !== 1'b1 && cycles < DRAIN_BOUND) begin
			@(negedge i_clock);
			#1;
			cycles++;
		end
		if (o_empty !== 1'b1) begin
			other_errors++;
			$display("Queue still not empty %0d cycles after the last write, at %0t",
				DRAIN_BOUND, $time);
		end
		@(negedge i_clock);
	endtask

	initial begin
		int done;
		int choice;
		int burst_len;

		i_rst = 1'b1;
		i_request = 1'b0;
		i_rw = 1'b0;
		i_address = '0;
		i_wdata = '0;
		void'($urandom(SEED));

		repeat (RESET_CYCLES) begin
			@(negedge i_clock);
			check_idle_outputs();
		end
		i_rst = 1'b0;
		@(negedge i_clock);
		check_idle_outputs();

		done = 0;
		while (done < N_TRANSFERS) begin
			choice = int'($urandom % 100);
			if (choice < 3) begin
				// Long enough to fill the queue and meet back-pressure
				burst_len = WQ_DEPTH + int'($urandom % WQ_DEPTH);
				if (burst_len > N_TRANSFERS - done)
					burst_len = N_TRANSFERS - done;
				repeat (burst_len)
					run_transfer(1'b1, build_address($urandom % HOT_WORDS), $urandom);
				done += burst_len;
				check_drain();
			end else begin
				run_transfer(choice < 47, build_address($urandom % HOT_WORDS), $urandom);
				done++;
				if ($urandom % 4 == 0)
					idle_cycles(1 + int'($urandom % 4));
			end
		end
		check_drain();

		// Words above the hot range are never written
		repeat (N_UNTOUCHED)
			run_transfer(1'b0, build_address(HOT_WORDS + ($urandom % (RAM_WORDS - HOT_WORDS))),
				$urandom);
		idle_cycles(1);

		$display("Summary: %0d writes, %0d reads checked, %0d mismatches, %0d other errors",
			writes_done, reads_checked, mismatch_errors, other_errors);
		if (mismatch_errors == 0 && other_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: wb_fifo.sv
`timescale 1ns/1ns

module wb_fifo #(
	parameter int DEPTH = 8
)(
	input logic i_clock,
	input logic i_rst,
	fifo_if.queue q
);
	import wb_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	write_entry_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	// Pointer advance with wrap for any depth
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign push = q.write && !q.full;
	assign pop = q.read && !q.empty;

	// Flags come straight from the count
	assign q.empty = (count == '0);
	assign q.full = (count == CNT_W'(DEPTH));

	// First-word fall-through head
	assign q.rdata = mem[rd_ptr];

	always_ff @(posedge i_clock) begin
		if (push)
			mem[wr_ptr] <= q.wdata;
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);

			// Simultaneous push and pop leave the count alone
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: wb_pkg.sv
package wb_pkg;

	// Processor and memory bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// Posted writes held before they reach the bus
	localparam int WQ_DEPTH = 8;

	// RAM slave geometry, word index taken from address bits 9:2
	localparam int RAM_WORDS = 256;
	localparam int RAM_IDX_W = 8;

	// One queued write, address in the upper half
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} write_entry_t;

endpackage

// File: wb_subsystem.sv
`timescale 1ns/1ns

module wb_subsystem #(
	parameter bit P_STALL_READ = 1'b1
)(
	input logic i_clock,
	input logic i_rst,

	// Processor port
	input logic i_request,
	input logic i_rw,
	input logic [wb_pkg::ADDR_W-1:0] i_address,
	input logic [wb_pkg::DATA_W-1:0] i_wdata,
	output logic o_ready,
	output logic [wb_pkg::DATA_W-1:0] o_rdata,

	// High once every posted write has left the queue
	output logic o_empty
);
	import wb_pkg::*;

	fifo_if wq_if ();
	mem_bus_if bus_if ();

	wb_fifo #(
		.DEPTH(WQ_DEPTH)
	) wb_fifo_i (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.q(wq_if.queue)
	);

	write_buffer #(
		.STALL_READ(P_STALL_READ)
	) write_buffer_i (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_empty(o_empty),
		.wq(wq_if.ctrl),
		.bus(bus_if.master)
	);

	// Memory with variable wait states behind the buffer
	bus_ram bus_ram_i (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.bus(bus_if.slave)
	);

endmodule

// File: wb_subsystem_assert.sv
`timescale 1ns/1ns

module wb_subsystem_assert (
	input logic i_clock,
	input logic i_rst,
	input logic i_request,
	input logic i_ready,
	input logic i_bus_request,
	input logic i_bus_rw,
	input logic [wb_pkg::ADDR_W-1:0] i_bus_address,
	input logic i_bus_ready
);
	// Cycles the current bus request has waited, saturating
	logic [2:0] wait_cycles;

	always_ff @(posedge i_clock) begin
		if (i_rst || !i_bus_request || i_bus_ready)
			wait_cycles <= 3'd0;
		else if (wait_cycles != 3'd7)
			wait_cycles <= wait_cycles + 3'd1;
	end

	held_request: assert property (@(posedge i_clock) disable iff (i_rst)
		i_bus_request && !i_bus_ready |=>
			i_bus_request && $stable(i_bus_address) && $stable(i_bus_rw))
		else $error("bus request, address or rw changed before ready");

	ready_needs_request: assert property (@(posedge i_clock) disable iff (i_rst)
		i_bus_ready |-> i_bus_request)
		else $error("bus ready without a request");

	cpu_ready_needs_request: assert property (@(posedge i_clock) disable iff (i_rst)
		i_ready |-> i_request)
		else $error("o_ready high while i_request is low");

	// Ready is due at most 4 cycles after the request rises
	ready_in_time: assert property (@(posedge i_clock) disable iff (i_rst)
		i_bus_request |-> wait_cycles <= 3'd4)
		else $error("bus ready later than 4 cycles after request");

endmodule

bind wb_subsystem wb_subsystem_assert wb_subsystem_assert_i (
	.i_clock(i_clock),
	.i_rst(i_rst),
	.i_request(i_request),
	.i_ready(o_ready),
	.i_bus_request(bus_if.request),
	.i_bus_rw(bus_if.rw),
	.i_bus_address(bus_if.address),
	.i_bus_ready(bus_if.ready)
);

// File: write_buffer.sv
`timescale 1ns/1ns

module write_buffer #(
	parameter bit STALL_READ = 1'b1
)(
	input logic i_clock,
	input logic i_rst,

	// Processor side
	input logic i_request,
	input logic i_rw,
	input logic [wb_pkg::ADDR_W-1:0] i_address,
	input logic [wb_pkg::DATA_W-1:0] i_wdata,
	output logic o_ready,
	output logic [wb_pkg::DATA_W-1:0] o_rdata,

	// Queue status
	output logic o_empty,

	fifo_if.ctrl wq,
	mem_bus_if.master bus
);
	import wb_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_DRAIN
	} state_t;

	state_t state;
	state_t next_state;
	write_entry_t drain_q;
	logic load_drain;
	logic stall_read;

	// Reads wait behind pending writes so they see the newest data
	assign stall_read = STALL_READ && !wq.empty;
	assign o_empty = wq.empty;

	always_ff @(posedge i_clock) begin
		if (i_rst)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	// Entry being written out is held while the bus stalls
	always_ff @(posedge i_clock) begin
		if (load_drain)
			drain_q <= wq.rdata;
	end

	always_comb begin
		next_state = state;
		load_drain = 1'b0;

		wq.write = 1'b0;
		wq.wdata = '0;
		wq.read = 1'b0;

		bus.request = 1'b0;
		bus.rw = 1'b0;
		bus.address = '0;
		bus.wdata = '0;

		o_ready = 1'b0;
		o_rdata = '0;

		case (state)
			ST_IDLE: begin
				if (i_request && i_rw && !wq.full) begin
					// Posted write is acknowledged as soon as it is queued
					wq.write = 1'b1;
					wq.wdata.addr = i_address;
					wq.wdata.data = i_wdata;
					o_ready = 1'b1;
				end else if (i_request && !i_rw && !stall_read) begin
					// Read goes straight out on the bus
					bus.request = 1'b1;
					bus.address = i_address;
					next_state = ST_READ;
				end else if (!wq.empty) begin
					// Nothing to serve so the head starts going out now
					wq.read = 1'b1;
					load_drain = 1'b1;
					bus.request = 1'b1;
					bus.rw = 1'b1;
					bus.address = wq.rdata.addr;
					bus.wdata = wq.rdata.data;
					next_state = ST_DRAIN;
				end
			end

			ST_READ: begin
				bus.request = 1'b1;
				bus.address = i_address;
				o_ready = bus.ready;
				if (bus.ready) begin
					o_rdata = bus.rdata;
					next_state = ST_IDLE;
				end
			end

			ST_DRAIN: begin
				// Same entry as the pop cycle so the bus sees stable values
				bus.request = 1'b1;
				bus.rw = 1'b1;
				bus.address = drain_q.addr;
				bus.wdata = drain_q.data;
				if (bus.ready)
					next_state = ST_IDLE;
			end

			default: begin
				next_state = ST_IDLE;
			end
		endcase
	end

endmodule
